// ==== logic/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

   // major opcodes of the RV64I integer, jump, branch, load and store groups.
   localparam logic [6:0] OPC_LOAD     = 7'b0000011;
   localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
   localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
   localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
   localparam logic [6:0] OPC_STORE    = 7'b0100011;
   localparam logic [6:0] OPC_OP       = 7'b0110011;
   localparam logic [6:0] OPC_LUI      = 7'b0110111;
   localparam logic [6:0] OPC_OP32     = 7'b0111011;
   localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
   localparam logic [6:0] OPC_JALR     = 7'b1100111;
   localparam logic [6:0] OPC_JAL      = 7'b1101111;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
      ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
      ALU_PASS_B, ALU_LINK
   } alu_op_e;

   // operand a is rs1 or pc, operand b is rs2 or the immediate.
   typedef enum logic [1:0] {
      OPND_RS1_RS2,
      OPND_RS1_IMM,
      OPND_PC_IMM
   } opnd_sel_e;

   // the encoding follows funct3[1:0] of loads and stores.
   typedef enum logic [1:0] {
      MEM_BYTE,
      MEM_HALF,
      MEM_WORD,
      MEM_DOUBLE
   } mem_size_e;

   typedef struct packed {
      logic [63:0] pc;
      logic [31:0] insn;
   } fetch_pkt_t;

   typedef struct packed {
      alu_op_e     alu_op;
      opnd_sel_e   opnd_sel;
      logic [63:0] imm;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic        rs1_re;
      logic        rs2_re;
      logic        we;
      logic        load;
      logic        store;
      mem_size_e   mem_size;
      logic        sext;
      logic        is_branch;
      logic        is_jump;
      logic        illegal;
   } decoded_t;

   typedef struct packed {
      logic [63:0] pc;
      decoded_t    dec;
      logic [63:0] op_a;
      logic [63:0] op_b;
      logic [63:0] store_data;
   } issue_pkt_t;

   typedef struct packed {
      logic        load;
      logic        store;
      mem_size_e   size;
      logic        sext;
      logic [63:0] addr;
      logic [63:0] data;
   } mem_req_t;

   typedef struct packed {
      logic [63:0] pc;
      logic [4:0]  rd;
      logic        we;
      logic [63:0] wdata;
      logic        taken;
      logic [63:0] target;
      logic        illegal;
      mem_req_t    mem;
   } exec_result_t;

endpackage

`default_nettype wire

// ==== logic/insn_decoder.sv ====
`default_nettype none

module insn_decoder import rv_exec_pkg::*; (
   input  logic [31:0] i_insn,
   output decoded_t    o_dec
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        f7_zero;
   logic        f7_alt;
   logic        legal;
   logic [63:0] imm_i;
   logic [63:0] imm_s;
   logic [63:0] imm_b;
   logic [63:0] imm_u;
   logic [63:0] imm_j;

   assign opcode  = i_insn[6:0];
   assign funct3  = i_insn[14:12];
   assign funct7  = i_insn[31:25];
   assign f7_zero = (funct7 == 7'b0000000);
   assign f7_alt  = (funct7 == 7'b0100000);

   assign imm_i = {{52{i_insn[31]}}, i_insn[31:20]};
   assign imm_s = {{52{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_b = {{52{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
   assign imm_u = {{32{i_insn[31]}}, i_insn[31:12], 12'b0};
   assign imm_j = {{44{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

   function automatic alu_op_e full_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  full_op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  full_op = ALU_SLL;
         3'b010:  full_op = ALU_SLT;
         3'b011:  full_op = ALU_SLTU;
         3'b100:  full_op = ALU_XOR;
         3'b101:  full_op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  full_op = ALU_OR;
         default: full_op = ALU_AND;
      endcase
   endfunction

   function automatic alu_op_e word_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b001:  word_op = ALU_SLLW;
         3'b101:  word_op = alt ? ALU_SRAW : ALU_SRLW;
         default: word_op = alt ? ALU_SUBW : ALU_ADDW;
      endcase
   endfunction

   always_comb begin
      o_dec          = '0;
      o_dec.rd       = i_insn[11:7];
      o_dec.rs1      = i_insn[19:15];
      o_dec.rs2      = i_insn[24:20];
      o_dec.mem_size = mem_size_e'(funct3[1:0]);
      legal          = 1'b0;
      case (opcode)
         OPC_LUI: begin
            legal          = 1'b1;
            o_dec.we       = 1'b1;
            o_dec.alu_op   = ALU_PASS_B;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_u;
         end
         OPC_AUIPC: begin
            legal          = 1'b1;
            o_dec.we       = 1'b1;
            o_dec.opnd_sel = OPND_PC_IMM;
            o_dec.imm      = imm_u;
         end
         OPC_JAL: begin
            legal          = 1'b1;
            o_dec.we       = 1'b1;
            o_dec.is_jump  = 1'b1;
            o_dec.alu_op   = ALU_LINK;
            o_dec.opnd_sel = OPND_PC_IMM;
            o_dec.imm      = imm_j;
         end
         OPC_JALR: begin
            legal          = (funct3 == 3'b000);
            o_dec.we       = 1'b1;
            o_dec.is_jump  = 1'b1;
            o_dec.rs1_re   = 1'b1;
            o_dec.alu_op   = ALU_LINK;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_i;
         end
         OPC_BRANCH: begin
            legal           = (funct3[2:1] != 2'b01);
            o_dec.is_branch = 1'b1;
            o_dec.rs1_re    = 1'b1;
            o_dec.rs2_re    = 1'b1;
            o_dec.imm       = imm_b;
            case (funct3)
               3'b000:  o_dec.alu_op = ALU_BEQ;
               3'b001:  o_dec.alu_op = ALU_BNE;
               3'b100:  o_dec.alu_op = ALU_BLT;
               3'b101:  o_dec.alu_op = ALU_BGE;
               3'b110:  o_dec.alu_op = ALU_BLTU;
               default: o_dec.alu_op = ALU_BGEU;
            endcase
         end
         OPC_LOAD: begin
            // load data never returns here, so a load writes no register.
            legal          = (funct3 != 3'b111);
            o_dec.load     = 1'b1;
            o_dec.sext     = !funct3[2];
            o_dec.rs1_re   = 1'b1;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_i;
         end
         OPC_STORE: begin
            legal          = !funct3[2];
            o_dec.store    = 1'b1;
            o_dec.rs1_re   = 1'b1;
            o_dec.rs2_re   = 1'b1;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_s;
         end
         OPC_OP_IMM: begin
            // shifts keep six shamt bits, so only funct7[6:1] is fixed.
            legal = (funct3 == 3'b001) ? (funct7[6:1] == 6'b000000) :
                    (funct3 == 3'b101) ? (funct7[6:1] == 6'b000000 ||
                                          funct7[6:1] == 6'b010000) : 1'b1;
            o_dec.we       = 1'b1;
            o_dec.rs1_re   = 1'b1;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_i;
            o_dec.alu_op   = full_op(funct3, funct3 == 3'b101 && funct7[5]);
         end
         OPC_OP: begin
            legal        = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            o_dec.we     = 1'b1;
            o_dec.rs1_re = 1'b1;
            o_dec.rs2_re = 1'b1;
            o_dec.alu_op = full_op(funct3, f7_alt);
         end
         OPC_OP_IMM32: begin
            legal = (funct3 == 3'b000) || (funct3 == 3'b001 && f7_zero) ||
                    (funct3 == 3'b101 && (f7_zero || f7_alt));
            o_dec.we       = 1'b1;
            o_dec.rs1_re   = 1'b1;
            o_dec.opnd_sel = OPND_RS1_IMM;
            o_dec.imm      = imm_i;
            o_dec.alu_op   = word_op(funct3, funct3 == 3'b101 && f7_alt);
         end
         OPC_OP32: begin
            legal = (funct3 == 3'b001 && f7_zero) ||
                    ((funct3 == 3'b000 || funct3 == 3'b101) && (f7_zero || f7_alt));
            o_dec.we     = 1'b1;
            o_dec.rs1_re = 1'b1;
            o_dec.rs2_re = 1'b1;
            o_dec.alu_op = word_op(funct3, f7_alt);
         end
         default: begin
            legal = 1'b0;
         end
      endcase
      o_dec.we = o_dec.we && (o_dec.rd != 5'd0);
      // an illegal encoding leaves no trace apart from its flag.
      if (!legal) begin
         o_dec         = '0;
         o_dec.illegal = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic [4:0]  i_rs1_addr,
   input  logic [4:0]  i_rs2_addr,
   output logic [63:0] o_rs1_data,
   output logic [63:0] o_rs2_data,
   input  logic        i_we,
   input  logic [4:0]  i_rd_addr,
   input  logic [63:0] i_rd_data
);

   logic [63:0] regs [32];

   // entry 0 is cleared at reset and never written, so x0 reads zero.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd_addr != 5'd0) begin
         regs[i_rd_addr] <= i_rd_data;
      end
   end

   assign o_rs1_data = regs[i_rs1_addr];
   assign o_rs2_data = regs[i_rs2_addr];

endmodule

`default_nettype wire

// ==== logic/issue_stage.sv ====
`default_nettype none

module issue_stage import rv_exec_pkg::*; (
   input  logic         i_clk,
   input  logic         i_rst_n,
   input  fetch_pkt_t   i_fetch,
   input  logic         i_fetch_valid,
   output logic         o_fetch_ready,
   output logic [31:0]  o_insn,
   input  decoded_t     i_dec,
   output logic [4:0]   o_rs1_addr,
   output logic [4:0]   o_rs2_addr,
   input  logic [63:0]  i_rs1_data,
   input  logic [63:0]  i_rs2_data,
   input  exec_result_t i_fwd,
   input  logic         i_fwd_valid,
   output issue_pkt_t   o_issue,
   output logic         o_issue_valid,
   input  logic         i_issue_ready
);

   fetch_pkt_t  fetch_q;
   logic [63:0] rs1_val;
   logic [63:0] rs2_val;

   assign o_fetch_ready = !o_issue_valid || i_issue_ready;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_issue_valid <= 1'b0;
      end else if (o_fetch_ready) begin
         o_issue_valid <= i_fetch_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_fetch_ready && i_fetch_valid) begin
         fetch_q <= i_fetch;
      end
   end

   assign o_insn     = fetch_q.insn;
   assign o_rs1_addr = i_dec.rs1_re ? i_dec.rs1 : 5'd0;
   assign o_rs2_addr = i_dec.rs2_re ? i_dec.rs2 : 5'd0;

   // the packet only moves while the result ahead leaves, and the register
   // file is written on that same edge, so the result is the only bypass.
   assign rs1_val = (i_fwd_valid && i_fwd.we && i_fwd.rd == o_rs1_addr) ?
                    i_fwd.wdata : i_rs1_data;
   assign rs2_val = (i_fwd_valid && i_fwd.we && i_fwd.rd == o_rs2_addr) ?
                    i_fwd.wdata : i_rs2_data;

   always_comb begin
      o_issue.pc         = fetch_q.pc;
      o_issue.dec        = i_dec;
      o_issue.store_data = rs2_val;
      case (i_dec.opnd_sel)
         OPND_PC_IMM: begin
            o_issue.op_a = fetch_q.pc;
            o_issue.op_b = i_dec.imm;
         end
         OPND_RS1_IMM: begin
            o_issue.op_a = rs1_val;
            o_issue.op_b = i_dec.imm;
         end
         default: begin
            o_issue.op_a = rs1_val;
            o_issue.op_b = rs2_val;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/int_alu.sv ====
`default_nettype none

module int_alu import rv_exec_pkg::*; (
   input  alu_op_e     i_op,
   input  logic [63:0] i_a,
   input  logic [63:0] i_b,
   input  logic [63:0] i_pc,
   output logic [63:0] o_value,
   output logic        o_taken
);

   logic        eq;
   logic        lt;
   logic        ltu;
   logic [31:0] word;

   assign eq  = (i_a == i_b);
   assign lt  = ($signed(i_a) < $signed(i_b));
   assign ltu = (i_a < i_b);

   // word forms work on the low half and sign-extend bit 31 of it.
   always_comb begin
      case (i_op)
         ALU_ADDW: word = i_a[31:0] + i_b[31:0];
         ALU_SUBW: word = i_a[31:0] - i_b[31:0];
         ALU_SLLW: word = i_a[31:0] << i_b[4:0];
         ALU_SRLW: word = i_a[31:0] >> i_b[4:0];
         ALU_SRAW: word = $signed(i_a[31:0]) >>> i_b[4:0];
         default:  word = '0;
      endcase
   end

   always_comb begin
      o_value = '0;
      o_taken = 1'b0;
      case (i_op)
         ALU_ADD:    o_value = i_a + i_b;
         ALU_SUB:    o_value = i_a - i_b;
         ALU_AND:    o_value = i_a & i_b;
         ALU_OR:     o_value = i_a | i_b;
         ALU_XOR:    o_value = i_a ^ i_b;
         ALU_SLL:    o_value = i_a << i_b[5:0];
         ALU_SRL:    o_value = i_a >> i_b[5:0];
         ALU_SRA:    o_value = $signed(i_a) >>> i_b[5:0];
         ALU_SLT:    o_value = {63'b0, lt};
         ALU_SLTU:   o_value = {63'b0, ltu};
         ALU_ADDW,
         ALU_SUBW,
         ALU_SLLW,
         ALU_SRLW,
         ALU_SRAW:   o_value = {{32{word[31]}}, word};
         ALU_BEQ:    o_taken = eq;
         ALU_BNE:    o_taken = !eq;
         ALU_BLT:    o_taken = lt;
         ALU_BGE:    o_taken = !lt;
         ALU_BLTU:   o_taken = ltu;
         ALU_BGEU:   o_taken = !ltu;
         ALU_PASS_B: o_value = i_b;
         ALU_LINK:   o_value = i_pc + 64'd4;
         default:    o_value = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/exec_stage.sv ====
`default_nettype none

module exec_stage import rv_exec_pkg::*; (
   input  logic         i_clk,
   input  logic         i_rst_n,
   input  issue_pkt_t   i_issue,
   input  logic         i_issue_valid,
   output logic         o_issue_ready,
   output exec_result_t o_result,
   output logic         o_result_valid,
   input  logic         i_result_ready,
   output logic         o_rf_we,
   output logic [4:0]   o_rf_rd,
   output logic [63:0]  o_rf_data
);

   logic [63:0]  alu_value;
   logic         alu_taken;
   logic [63:0]  base_imm;
   exec_result_t res_d;

   int_alu u_alu (
      .i_op    (i_issue.dec.alu_op),
      .i_a     (i_issue.op_a),
      .i_b     (i_issue.op_b),
      .i_pc    (i_issue.pc),
      .o_value (alu_value),
      .o_taken (alu_taken)
   );

   // jal selects pc as operand a, so this sum is the target of both jumps.
   assign base_imm = i_issue.op_a + i_issue.dec.imm;

   always_comb begin
      res_d         = '0;
      res_d.pc      = i_issue.pc;
      res_d.rd      = i_issue.dec.rd;
      res_d.we      = i_issue.dec.we;
      res_d.wdata   = alu_value;
      res_d.illegal = i_issue.dec.illegal;
      if (i_issue.dec.is_jump) begin
         res_d.taken  = 1'b1;
         res_d.target = {base_imm[63:1], 1'b0};
      end else if (i_issue.dec.is_branch) begin
         res_d.taken  = alu_taken;
         res_d.target = i_issue.pc + i_issue.dec.imm;
      end
      if (i_issue.dec.load || i_issue.dec.store) begin
         res_d.mem.load  = i_issue.dec.load;
         res_d.mem.store = i_issue.dec.store;
         res_d.mem.size  = i_issue.dec.mem_size;
         res_d.mem.sext  = i_issue.dec.sext;
         res_d.mem.addr  = base_imm;
         res_d.mem.data  = i_issue.dec.store ? i_issue.store_data : '0;
      end
   end

   assign o_issue_ready = !o_result_valid || i_result_ready;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_result_valid <= 1'b0;
      end else if (o_issue_ready) begin
         o_result_valid <= i_issue_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_issue_ready && i_issue_valid) begin
         o_result <= res_d;
      end
   end

   // the register file is written on the edge the result leaves.
   assign o_rf_we   = o_result_valid && i_result_ready && o_result.we;
   assign o_rf_rd   = o_result.rd;
   assign o_rf_data = o_result.wdata;

endmodule

`default_nettype wire

// ==== logic/decode_exec_top.sv ====
`default_nettype none

module decode_exec_top import rv_exec_pkg::*; (
   input  logic         i_clk,
   input  logic         i_rst_n,
   input  fetch_pkt_t   i_fetch,
   input  logic         i_fetch_valid,
   output logic         o_fetch_ready,
   output exec_result_t o_result,
   output logic         o_result_valid,
   input  logic         i_result_ready
);

   logic [31:0] insn;
   decoded_t    dec;
   logic [4:0]  rs1_addr;
   logic [4:0]  rs2_addr;
   logic [63:0] rs1_data;
   logic [63:0] rs2_data;
   issue_pkt_t  issue;
   logic        issue_valid;
   logic        issue_ready;
   logic        rf_we;
   logic [4:0]  rf_rd;
   logic [63:0] rf_data;

   insn_decoder u_dec (
      .i_insn (insn),
      .o_dec  (dec)
   );

   reg_file u_rf (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (rf_we),
      .i_rd_addr  (rf_rd),
      .i_rd_data  (rf_data)
   );

   issue_stage u_issue (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_fetch       (i_fetch),
      .i_fetch_valid (i_fetch_valid),
      .o_fetch_ready (o_fetch_ready),
      .o_insn        (insn),
      .i_dec         (dec),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .i_rs1_data    (rs1_data),
      .i_rs2_data    (rs2_data),
      .i_fwd         (o_result),
      .i_fwd_valid   (o_result_valid),
      .o_issue       (issue),
      .o_issue_valid (issue_valid),
      .i_issue_ready (issue_ready)
   );

   exec_stage u_exec (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_issue        (issue),
      .i_issue_valid  (issue_valid),
      .o_issue_ready  (issue_ready),
      .o_result       (o_result),
      .o_result_valid (o_result_valid),
      .i_result_ready (i_result_ready),
      .o_rf_we        (rf_we),
      .o_rf_rd        (rf_rd),
      .o_rf_data      (rf_data)
   );

endmodule

`default_nettype wire

// ==== testbench/decode_exec_props.sv ====
`default_nettype none

module decode_exec_props import rv_exec_pkg::*; (
   input logic         i_clk,
   input logic         i_rst_n,
   input exec_result_t i_result,
   input logic         i_result_valid,
   input logic         i_result_ready,
   input logic         i_rf_we,
   input logic [4:0]   i_rf_rd
);

   int failures = 0;

   // a result held back by the consumer stays put until it is taken.
   stalled_result_stable: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      (i_result_valid && !i_result_ready) |=> (i_result_valid && $stable(i_result))
   ) else begin
      $error("o_result changed or dropped while stalled");
      failures++;
   end

   valid_low_in_reset: assert property (
      @(posedge i_clk) !i_rst_n |-> !i_result_valid
   ) else begin
      $error("o_result_valid is high during reset");
      failures++;
   end

   no_rf_write_to_x0: assert property (
      @(posedge i_clk) disable iff (!i_rst_n) i_rf_we |-> (i_rf_rd != 5'd0)
   ) else begin
      $error("register file write enable with rd zero");
      failures++;
   end

endmodule

bind decode_exec_top decode_exec_props u_props (
   .i_clk          (i_clk),
   .i_rst_n        (i_rst_n),
   .i_result       (o_result),
   .i_result_valid (o_result_valid),
   .i_result_ready (i_result_ready),
   .i_rf_we        (rf_we),
   .i_rf_rd        (rf_rd)
);

`default_nettype wire

// ==== testbench/decode_exec_tb.sv ====
`default_nettype none

module decode_exec_tb import rv_exec_pkg::*; ();

   localparam int    HALF_PERIOD = 50;
   localparam int    RESET_CYCLES = 8;
   localparam string GOLDEN_PATH = "testbench/decode_exec_golden.txt";

   logic         clk;
   logic         rst_n;
   fetch_pkt_t   fetch;
   logic         fetch_valid;
   logic         fetch_ready;
   exec_result_t result;
   logic         result_valid;
   logic         result_ready;

   fetch_pkt_t   stim [$];
   exec_result_t golden [$];
   exec_result_t in_flight [$];
   integer       seed;
   int           limit;
   int           sent;
   int           received;

   decode_exec_top u_dut (
      .i_clk          (clk),
      .i_rst_n        (rst_n),
      .i_fetch        (fetch),
      .i_fetch_valid  (fetch_valid),
      .o_fetch_ready  (fetch_ready),
      .o_result       (result),
      .o_result_valid (result_valid),
      .i_result_ready (result_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #HALF_PERIOD clk = ~clk;
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string field, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("** Error at time %0t: %s is %h, expected %h", $time, field, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch");
   endtask

   // rd and wdata only matter with a write, the target only when taken.
   task automatic check_result(input exec_result_t got, input exec_result_t exp);
      if (got.pc !== exp.pc)
         report_mismatch("pc", got.pc, exp.pc);
      if (got.illegal !== exp.illegal)
         report_mismatch($sformatf("illegal of pc %h", exp.pc), got.illegal, exp.illegal);
      if (got.we !== exp.we)
         report_mismatch($sformatf("we of pc %h", exp.pc), got.we, exp.we);
      if (exp.we && got.rd !== exp.rd)
         report_mismatch($sformatf("rd of pc %h", exp.pc), got.rd, exp.rd);
      if (exp.we && got.wdata !== exp.wdata)
         report_mismatch($sformatf("wdata of pc %h", exp.pc), got.wdata, exp.wdata);
      if (got.taken !== exp.taken)
         report_mismatch($sformatf("taken of pc %h", exp.pc), got.taken, exp.taken);
      if (exp.taken && got.target !== exp.target)
         report_mismatch($sformatf("target of pc %h", exp.pc), got.target, exp.target);
   endtask

   task automatic check_mem(input mem_req_t got, input mem_req_t exp);
      if (got.load !== exp.load)
         report_mismatch("mem load", got.load, exp.load);
      if (got.store !== exp.store)
         report_mismatch("mem store", got.store, exp.store);
      if (got.size !== exp.size)
         report_mismatch("mem size", got.size, exp.size);
      if (got.sext !== exp.sext)
         report_mismatch("mem sext", got.sext, exp.sext);
      if (got.addr !== exp.addr)
         report_mismatch("mem addr", got.addr, exp.addr);
      if (got.data !== exp.data)
         report_mismatch("mem data", got.data, exp.data);
   endtask

   // each data line holds the fetch packet and the full expected result.
   task automatic load_golden();
      int           fd;
      int           count;
      string        line;
      logic [63:0]  col [14];
      fetch_pkt_t   pkt;
      exec_result_t exp;
      fd = $fopen(GOLDEN_PATH, "r");
      if (fd == 0) begin
         abort_run("the golden file could not be opened");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                               col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
               if (count != 14) begin
                  abort_run($sformatf("a golden line could not be parsed: %s", line));
               end else begin
                  pkt.pc         = col[0];
                  pkt.insn       = col[1][31:0];
                  exp            = '0;
                  exp.pc         = col[0];
                  exp.rd         = col[2][4:0];
                  exp.we         = col[3][0];
                  exp.wdata      = col[4];
                  exp.taken      = col[5][0];
                  exp.target     = col[6];
                  exp.illegal    = col[7][0];
                  exp.mem.load   = col[8][0];
                  exp.mem.store  = col[9][0];
                  exp.mem.size   = mem_size_e'(col[10][1:0]);
                  exp.mem.sext   = col[11][0];
                  exp.mem.addr   = col[12];
                  exp.mem.data   = col[13];
                  stim.push_back(pkt);
                  golden.push_back(exp);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      abort_run($sformatf("the run timed out after %0d cycles", limit));
   end

   initial begin
      exec_result_t expected;
      seed         = 32'h0f09b063;
      rst_n        = 1'b0;
      fetch        = '0;
      fetch_valid  = 1'b0;
      result_ready = 1'b0;
      sent         = 0;
      received     = 0;
      load_golden();
      limit = golden.size() * 8 + 50;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      if (!fetch_ready || result_valid) begin
         abort_run("the DUT did not come out of reset idle");
      end
      while (received < golden.size()) begin
         @(negedge clk);
         // roughly one cycle in four stalls the output.
         result_ready = (($random(seed) & 3) != 0);
         fetch_valid  = (sent < stim.size());
         if (fetch_valid) begin
            fetch = stim[sent];
         end
         #1;
         if (u_dut.u_props.failures != 0) begin
            abort_run("a handshake assertion failed");
         end
         if (result_valid && result_ready) begin
            if (in_flight.size() == 0) begin
               abort_run("a result left while no instruction was in flight");
            end else begin
               expected = in_flight.pop_front();
               check_result(result, expected);
               check_mem(result.mem, expected.mem);
               received++;
            end
         end
         if (fetch_valid && fetch_ready) begin
            in_flight.push_back(golden[sent]);
            sent++;
         end
      end
      // the last result leaves on the next rising edge.
      @(negedge clk);
      if (u_dut.u_props.failures == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Checks failed");
         $fatal(1, "assertion failures during the run");
      end
   end

endmodule

`default_nettype wire

// ==== testbench/decode_exec_golden.txt ====
# pc insn rd we wdata taken target illegal load store size sext addr data, all in hex
# size 0 byte 1 half 2 word 3 double; rd and wdata count only with we, target only when taken
1000 ffb00093 01 1 fffffffffffffffb 0 0 0 0 0 0 0 0 0
1004 00700113 02 1 7 0 0 0 0 0 0 0 0 0
1008 002081b3 03 1 2 0 0 0 0 0 0 0 0 0
100c 40208233 04 1 fffffffffffffff4 0 0 0 0 0 0 0 0 0
1010 0020a2b3 05 1 1 0 0 0 0 0 0 0 0 0
1014 0020b333 06 1 0 0 0 0 0 0 0 0 0 0
1018 0020c3b3 07 1 fffffffffffffffc 0 0 0 0 0 0 0 0 0
101c 0020f433 08 1 3 0 0 0 0 0 0 0 0 0
1020 43f0d493 09 1 ffffffffffffffff 0 0 0 0 0 0 0 0 0
1024 03f0d513 0a 1 1 0 0 0 0 0 0 0 0 0
1028 03f11593 0b 1 8000000000000000 0 0 0 0 0 0 0 0 0
102c 80000637 0c 1 ffffffff80000000 0 0 0 0 0 0 0 0 0
1030 fff6069b 0d 1 7fffffff 0 0 0 0 0 0 0 0 0
1034 00d6873b 0e 1 fffffffffffffffe 0 0 0 0 0 0 0 0 0
1038 40d007bb 0f 1 ffffffff80000001 0 0 0 0 0 0 0 0 0
103c 00a6983b 10 1 fffffffffffffffe 0 0 0 0 0 0 0 0 0
1040 00a658bb 11 1 40000000 0 0 0 0 0 0 0 0 0
1044 40a6593b 12 1 ffffffffc0000000 0 0 0 0 0 0 0 0 0
1048 00108863 00 0 0 1 1058 0 0 0 0 0 0 0
104c 00109463 00 0 0 0 0 0 0 0 0 0 0 0
1050 fe20c8e3 00 0 0 1 1040 0 0 0 0 0 0 0
1054 0020e463 00 0 0 0 0 0 0 0 0 0 0 0
1058 0020f663 00 0 0 1 1064 0 0 0 0 0 0 0
105c 00115263 00 0 0 1 1060 0 0 0 0 0 0 0
1060 020009ef 13 1 1064 1 1080 0 0 0 0 0 0 0
1064 01010a67 14 1 1068 1 16 0 0 0 0 0 0 0
1068 12345a97 15 1 12346068 0 0 0 0 0 0 0 0 0
106c ff89bb03 00 0 0 0 0 0 1 0 3 1 105c 0
1070 0051cb83 00 0 0 0 0 0 1 0 0 0 7 0
1074 00209c03 00 0 0 0 0 0 1 0 1 1 fffffffffffffffd 0
1078 00413823 00 0 0 0 0 0 0 1 3 0 17 fffffffffffffff4
107c fef62e23 00 0 0 0 0 0 0 1 2 0 ffffffff7ffffffc ffffffff80000001
1080 7a500c93 19 1 7a5 0 0 0 0 0 0 0 0 0
1084 019c8023 00 0 0 0 0 0 0 1 0 0 7a5 7a5
1088 0ff0000f 00 0 0 0 0 1 0 0 0 0 0 0
108c 00000073 00 0 0 0 0 1 0 0 0 0 0 0
1090 ffffffff 00 0 0 0 0 1 0 0 0 0 0 0
1094 00908013 00 0 0 0 0 0 0 0 0 0 0 0
1098 00100d13 1a 1 1 0 0 0 0 0 0 0 0 0
109c 00406db3 1b 1 fffffffffffffff4 0 0 0 0 0 0 0 0 0

// ==== compile.f ====
logic/rv_exec_pkg.sv
logic/insn_decoder.sv
logic/reg_file.sv
logic/issue_stage.sv
logic/int_alu.sv
logic/exec_stage.sv
logic/decode_exec_top.sv
testbench/decode_exec_props.sv
testbench/decode_exec_tb.sv

// ==== Bender.yml ====
package:
  name: decode_exec

sources:
  - files:
      - logic/rv_exec_pkg.sv
      - logic/insn_decoder.sv
      - logic/reg_file.sv
      - logic/issue_stage.sv
      - logic/int_alu.sv
      - logic/exec_stage.sv
      - logic/decode_exec_top.sv
  - target: test
    files:
      - testbench/decode_exec_props.sv
      - testbench/decode_exec_tb.sv
